//--- verilog/core_pkg.sv
package core_pkg;
	localparam int XLEN = 32;
	localparam int NUM_REGS = 32;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;
	localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // ADDI x0, x0, 0.

	typedef enum logic [6:0] {
		OPC_LOAD = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_STORE = 7'b0100011,
		OPC_OP = 7'b0110011,
		OPC_LUI = 7'b0110111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS2
	} alu_op_e;

	typedef enum logic {
		ALU_IN2_REG2,
		ALU_IN2_IMM
	} alu_in2_sel_e;

	typedef enum logic {
		WR_SEL_ALU,
		WR_SEL_LOAD
	} wr_sel_e;

	typedef enum logic [1:0] {
		BYPASS_NONE,
		BYPASS_EX,
		BYPASS_MEM,
		BYPASS_WB
	} bypass_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		alu_in2_sel_e alu_in2_sel;
		wr_sel_e wr_sel;
		logic regfile_we;
		logic is_load;
		logic is_store;
		logic uses_rs1;
		logic uses_rs2;
	} decode_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
		logic valid;
	} id_reg_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] op2;
		logic [XLEN-1:0] imm;
		decode_t dec;
		logic valid;
	} ex_reg_t;

	typedef struct packed {
		logic [4:0] rd;
		logic [XLEN-1:0] alu_out;
		logic [XLEN-1:0] store_data;
		logic regfile_we;
		logic is_load;
		logic is_store;
		wr_sel_e wr_sel;
		logic valid;
	} mem_reg_t;

	typedef struct packed {
		logic [4:0] rd;
		logic [XLEN-1:0] alu_out;
		logic [XLEN-1:0] load_data;
		logic regfile_we;
		wr_sel_e wr_sel;
		logic valid;
	} wb_reg_t;

	typedef struct packed {
		logic pc_stall;
		logic id_stall;
		logic ex_stall;
		logic mem_stall;
		logic id_valid;
		logic ex_valid;
		logic mem_valid;
		logic wb_valid;
		bypass_sel_e bypass1;
		bypass_sel_e bypass2;
	} control_t;
endpackage

//--- verilog/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;
	logic access;
	logic [core_pkg::XLEN-1:0] addr;
	logic [core_pkg::XLEN-1:0] rd_data; // Valid in the cycle of the hit.
	logic hit;

	modport master (output access, output addr, input rd_data, input hit);
	modport slave (input access, input addr, output rd_data, output hit);
endinterface

//--- verilog/mem_if.sv
`timescale 1ns/1ps

interface mem_if;
	logic access;
	logic write;
	logic [core_pkg::XLEN-1:0] addr;
	logic [core_pkg::XLEN-1:0] wr_data;
	logic [core_pkg::XLEN-1:0] rd_data;
	logic hit;

	// An access completes in a cycle where access and hit are both high.
	modport master (
		output access, output write, output addr, output wr_data,
		input rd_data, input hit
	);
	modport slave (
		input access, input write, input addr, input wr_data,
		output rd_data, output hit
	);
endinterface

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
	input logic [core_pkg::XLEN-1:0] instr_i,
	output core_pkg::decode_t decode_o,
	output logic [core_pkg::XLEN-1:0] imm_o
);
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd;
	logic legal;

	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign rd = instr_i[11:7];

	always_comb begin
		decode_o = '0;
		imm_o = {{20{instr_i[31]}}, instr_i[31:20]}; // I-type unless overridden.
		legal = 1'b1;
		case (core_pkg::opcode_e'(instr_i[6:0]))
		core_pkg::OPC_OP_IMM: begin
			decode_o.alu_in2_sel = core_pkg::ALU_IN2_IMM;
			decode_o.uses_rs1 = 1'b1;
			decode_o.regfile_we = 1'b1;
			case (funct3)
			3'b000: decode_o.alu_op = core_pkg::ALU_ADD;
			3'b100: decode_o.alu_op = core_pkg::ALU_XOR;
			3'b110: decode_o.alu_op = core_pkg::ALU_OR;
			3'b111: decode_o.alu_op = core_pkg::ALU_AND;
			default: legal = 1'b0;
			endcase
		end
		core_pkg::OPC_OP: begin
			decode_o.uses_rs1 = 1'b1;
			decode_o.uses_rs2 = 1'b1;
			decode_o.regfile_we = 1'b1;
			case ({funct7, funct3})
			10'b0000000_000: decode_o.alu_op = core_pkg::ALU_ADD;
			10'b0100000_000: decode_o.alu_op = core_pkg::ALU_SUB;
			10'b0000000_100: decode_o.alu_op = core_pkg::ALU_XOR;
			10'b0000000_110: decode_o.alu_op = core_pkg::ALU_OR;
			10'b0000000_111: decode_o.alu_op = core_pkg::ALU_AND;
			default: legal = 1'b0;
			endcase
		end
		core_pkg::OPC_LUI: begin
			imm_o = {instr_i[31:12], 12'b0};
			decode_o.alu_op = core_pkg::ALU_PASS2;
			decode_o.alu_in2_sel = core_pkg::ALU_IN2_IMM;
			decode_o.regfile_we = 1'b1;
		end
		core_pkg::OPC_LOAD: begin
			legal = (funct3 == 3'b010); // Word loads only.
			decode_o.alu_in2_sel = core_pkg::ALU_IN2_IMM;
			decode_o.wr_sel = core_pkg::WR_SEL_LOAD;
			decode_o.uses_rs1 = 1'b1;
			decode_o.regfile_we = 1'b1;
			decode_o.is_load = 1'b1;
		end
		core_pkg::OPC_STORE: begin
			legal = (funct3 == 3'b010);
			imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
			decode_o.alu_in2_sel = core_pkg::ALU_IN2_IMM;
			decode_o.uses_rs1 = 1'b1;
			decode_o.uses_rs2 = 1'b1;
			decode_o.is_store = 1'b1;
		end
		default: legal = 1'b0;
		endcase

		if (!legal)
			decode_o = '0; // Anything unsupported retires as a no-op.
		if (rd == 5'd0)
			decode_o.regfile_we = 1'b0;
	end
endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
	input logic clk_i,
	input logic reset_i,
	input logic [4:0] rd_addr1_i,
	input logic [4:0] rd_addr2_i,
	input logic [4:0] wr_addr_i,
	input logic [core_pkg::XLEN-1:0] wr_data_i,
	input logic wr_en_i,
	output logic [core_pkg::XLEN-1:0] rd_data1_o,
	output logic [core_pkg::XLEN-1:0] rd_data2_o
);
	logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < core_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en_i && wr_addr_i != 5'd0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// A read during a write sees the old value. The WB bypass covers it.
	assign rd_data1_o = (rd_addr1_i == 5'd0) ? '0 : regs[rd_addr1_i];
	assign rd_data2_o = (rd_addr2_i == 5'd0) ? '0 : regs[rd_addr2_i];
endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
	input core_pkg::alu_op_e alu_op_i,
	input logic [core_pkg::XLEN-1:0] in1_i,
	input logic [core_pkg::XLEN-1:0] in2_i,
	output logic [core_pkg::XLEN-1:0] out_o
);
	always_comb begin
		case (alu_op_i)
		core_pkg::ALU_ADD:
			out_o = in1_i + in2_i;
		core_pkg::ALU_SUB:
			out_o = in1_i - in2_i;
		core_pkg::ALU_AND:
			out_o = in1_i & in2_i;
		core_pkg::ALU_OR:
			out_o = in1_i | in2_i;
		core_pkg::ALU_XOR:
			out_o = in1_i ^ in2_i;
		core_pkg::ALU_PASS2:
			out_o = in2_i; // Used by LUI.
		default:
			out_o = '0;
		endcase
	end
endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input core_pkg::id_reg_t id_reg_i,
	input core_pkg::ex_reg_t ex_reg_i,
	input core_pkg::mem_reg_t mem_reg_i,
	input core_pkg::wb_reg_t wb_reg_i,
	input core_pkg::decode_t id_decode_i,
	input logic imem_hit_i,
	input logic dmem_hit_i,
	output core_pkg::control_t control_o
);
	logic [4:0] id_rs1;
	logic [4:0] id_rs2;
	logic ex_writes;
	logic mem_writes;
	logic wb_writes;
	logic mem_miss;
	logic load_use;

	// Producers never have rd = x0, since the decoder clears their write enable.
	assign id_rs1 = id_reg_i.instr[19:15];
	assign id_rs2 = id_reg_i.instr[24:20];
	assign ex_writes = ex_reg_i.valid && ex_reg_i.dec.regfile_we;
	assign mem_writes = mem_reg_i.valid && mem_reg_i.regfile_we;
	assign wb_writes = wb_reg_i.valid && wb_reg_i.regfile_we;

	function automatic logic load_pending(input logic [4:0] rs);
		return (ex_writes && ex_reg_i.dec.is_load && ex_reg_i.rd == rs) ||
			(mem_writes && mem_reg_i.is_load && mem_reg_i.rd == rs);
	endfunction

	// Youngest producer wins. Loads in EX or MEM have no data yet.
	function automatic core_pkg::bypass_sel_e bypass_for(input logic [4:0] rs);
		if (ex_writes && !ex_reg_i.dec.is_load && ex_reg_i.rd == rs)
			return core_pkg::BYPASS_EX;
		if (mem_writes && !mem_reg_i.is_load && mem_reg_i.rd == rs)
			return core_pkg::BYPASS_MEM;
		if (wb_writes && wb_reg_i.rd == rs)
			return core_pkg::BYPASS_WB;
		return core_pkg::BYPASS_NONE;
	endfunction

	assign mem_miss = mem_reg_i.valid && (mem_reg_i.is_load || mem_reg_i.is_store) &&
		!dmem_hit_i;
	assign load_use = id_reg_i.valid &&
		((id_decode_i.uses_rs1 && load_pending(id_rs1)) ||
		(id_decode_i.uses_rs2 && load_pending(id_rs2)));

	always_comb begin
		control_o.pc_stall = mem_miss || load_use || !imem_hit_i;
		control_o.id_stall = mem_miss || load_use;
		control_o.ex_stall = mem_miss;
		control_o.mem_stall = mem_miss;

		control_o.id_valid = imem_hit_i; // A fetch miss becomes a bubble.
		control_o.ex_valid = id_reg_i.valid && !load_use;
		control_o.mem_valid = ex_reg_i.valid;
		control_o.wb_valid = mem_reg_i.valid && !mem_miss;

		control_o.bypass1 = bypass_for(id_rs1);
		control_o.bypass2 = bypass_for(id_rs2);
	end
endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ps

module datapath (
	input logic clk_i,
	input logic reset_i,
	fetch_if.master imem_bus,
	mem_if.master dmem_bus,
	output logic retire_valid_o,
	output logic retire_we_o,
	output logic [4:0] retire_rd_o,
	output logic [core_pkg::XLEN-1:0] retire_data_o
);
	logic [core_pkg::XLEN-1:0] pc;
	core_pkg::id_reg_t id_reg;
	core_pkg::ex_reg_t ex_reg;
	core_pkg::mem_reg_t mem_reg;
	core_pkg::wb_reg_t wb_reg;

	core_pkg::id_reg_t next_id_reg;
	core_pkg::ex_reg_t next_ex_reg;
	core_pkg::mem_reg_t next_mem_reg;
	core_pkg::wb_reg_t next_wb_reg;

	core_pkg::control_t control;
	core_pkg::decode_t id_decode;
	logic [core_pkg::XLEN-1:0] id_imm;
	logic [core_pkg::XLEN-1:0] id_rf_data1;
	logic [core_pkg::XLEN-1:0] id_rf_data2;
	logic [core_pkg::XLEN-1:0] ex_alu_in2;
	logic [core_pkg::XLEN-1:0] ex_alu_out;
	logic [core_pkg::XLEN-1:0] wb_wr_data;

	function automatic logic [core_pkg::XLEN-1:0] bypass_mux(
		input core_pkg::bypass_sel_e sel,
		input logic [core_pkg::XLEN-1:0] rf_data
	);
		case (sel)
		core_pkg::BYPASS_EX: return ex_alu_out;
		core_pkg::BYPASS_MEM: return mem_reg.alu_out;
		core_pkg::BYPASS_WB: return wb_wr_data;
		default: return rf_data;
		endcase
	endfunction

	hazard_unit hazard_unit (
		.id_reg_i(id_reg),
		.ex_reg_i(ex_reg),
		.mem_reg_i(mem_reg),
		.wb_reg_i(wb_reg),
		.id_decode_i(id_decode),
		.imem_hit_i(imem_bus.hit),
		.dmem_hit_i(dmem_bus.hit),
		.control_o(control)
	);

	// Fetch is only requested when ID can take the word.
	assign imem_bus.access = !control.id_stall;
	assign imem_bus.addr = pc;
	assign next_id_reg = '{pc: pc, instr: imem_bus.rd_data, valid: control.id_valid};

	decoder decoder (
		.instr_i(id_reg.instr),
		.decode_o(id_decode),
		.imm_o(id_imm)
	);

	regfile regfile (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rd_addr1_i(id_reg.instr[19:15]),
		.rd_addr2_i(id_reg.instr[24:20]),
		.wr_addr_i(wb_reg.rd),
		.wr_data_i(wb_wr_data),
		.wr_en_i(wb_reg.valid && wb_reg.regfile_we),
		.rd_data1_o(id_rf_data1),
		.rd_data2_o(id_rf_data2)
	);

	always_comb begin
		next_ex_reg.pc = id_reg.pc;
		next_ex_reg.rs1 = id_reg.instr[19:15];
		next_ex_reg.rs2 = id_reg.instr[24:20];
		next_ex_reg.rd = id_reg.instr[11:7];
		next_ex_reg.op1 = bypass_mux(control.bypass1, id_rf_data1);
		next_ex_reg.op2 = bypass_mux(control.bypass2, id_rf_data2);
		next_ex_reg.imm = id_imm;
		next_ex_reg.dec = id_decode;
		next_ex_reg.valid = control.ex_valid;
	end

	assign ex_alu_in2 = (ex_reg.dec.alu_in2_sel == core_pkg::ALU_IN2_IMM) ?
		ex_reg.imm : ex_reg.op2;

	alu alu (
		.alu_op_i(ex_reg.dec.alu_op),
		.in1_i(ex_reg.op1),
		.in2_i(ex_alu_in2),
		.out_o(ex_alu_out)
	);

	assign next_mem_reg = '{rd: ex_reg.rd, alu_out: ex_alu_out, store_data: ex_reg.op2,
		regfile_we: ex_reg.dec.regfile_we, is_load: ex_reg.dec.is_load,
		is_store: ex_reg.dec.is_store, wr_sel: ex_reg.dec.wr_sel, valid: control.mem_valid};

	assign dmem_bus.access = mem_reg.valid && (mem_reg.is_load || mem_reg.is_store);
	assign dmem_bus.write = mem_reg.valid && mem_reg.is_store;
	assign dmem_bus.addr = mem_reg.alu_out;
	assign dmem_bus.wr_data = mem_reg.store_data;

	assign next_wb_reg = '{rd: mem_reg.rd, alu_out: mem_reg.alu_out,
		load_data: dmem_bus.rd_data, regfile_we: mem_reg.regfile_we,
		wr_sel: mem_reg.wr_sel, valid: control.wb_valid};

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc <= core_pkg::RESET_PC;
			id_reg <= '0;
			ex_reg <= '0;
			mem_reg <= '0;
			wb_reg <= '0;
		end else begin
			if (!control.pc_stall)
				pc <= pc + 32'd4;
			if (!control.id_stall)
				id_reg <= next_id_reg;
			if (!control.ex_stall)
				ex_reg <= next_ex_reg;
			if (!control.mem_stall)
				mem_reg <= next_mem_reg;
			wb_reg <= next_wb_reg; // WB never stalls.
		end
	end

	assign wb_wr_data = (wb_reg.wr_sel == core_pkg::WR_SEL_LOAD) ?
		wb_reg.load_data : wb_reg.alu_out;

	assign retire_valid_o = wb_reg.valid;
	assign retire_we_o = wb_reg.valid && wb_reg.regfile_we;
	assign retire_rd_o = wb_reg.rd;
	assign retire_data_o = wb_wr_data;
endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top (
	input logic clk_i,
	input logic reset_i,
	output logic imem_access_o,
	output logic [core_pkg::XLEN-1:0] imem_addr_o,
	input logic [core_pkg::XLEN-1:0] imem_rd_data_i,
	input logic imem_hit_i,
	output logic dmem_access_o,
	output logic dmem_write_o,
	output logic [core_pkg::XLEN-1:0] dmem_addr_o,
	output logic [core_pkg::XLEN-1:0] dmem_wr_data_o,
	input logic [core_pkg::XLEN-1:0] dmem_rd_data_i,
	input logic dmem_hit_i,
	output logic retire_valid_o,
	output logic retire_we_o,
	output logic [4:0] retire_rd_o,
	output logic [core_pkg::XLEN-1:0] retire_data_o
);
	fetch_if imem_bus ();
	mem_if dmem_bus ();

	datapath datapath (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.imem_bus(imem_bus),
		.dmem_bus(dmem_bus),
		.retire_valid_o(retire_valid_o),
		.retire_we_o(retire_we_o),
		.retire_rd_o(retire_rd_o),
		.retire_data_o(retire_data_o)
	);

	assign imem_access_o = imem_bus.access;
	assign imem_addr_o = imem_bus.addr;
	assign imem_bus.rd_data = imem_rd_data_i;
	assign imem_bus.hit = imem_hit_i;

	assign dmem_access_o = dmem_bus.access;
	assign dmem_write_o = dmem_bus.write;
	assign dmem_addr_o = dmem_bus.addr;
	assign dmem_wr_data_o = dmem_bus.wr_data;
	assign dmem_bus.rd_data = dmem_rd_data_i;
	assign dmem_bus.hit = dmem_hit_i;
endmodule

//--- sim/core_checker.sv
`timescale 1ns/1ps

module core_checker (
	input logic clk_i,
	input logic reset_i,
	input logic dmem_access_i,
	input logic dmem_write_i,
	input logic [core_pkg::XLEN-1:0] dmem_addr_i,
	input logic retire_valid_i,
	input logic retire_we_i,
	input logic [4:0] retire_rd_i
);
	int unsigned fail_count = 0; // Number of failed assertions.

	write_needs_access: assert property (@(posedge clk_i) disable iff (reset_i)
		dmem_write_i |-> dmem_access_i)
	else begin
		fail_count++;
		$error("Data write asserted without a data access.");
	end

	// Only word accesses exist.
	word_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
		dmem_access_i |-> dmem_addr_i[1:0] == 2'b00)
	else begin
		fail_count++;
		$error("Data access to an address that is not word aligned.");
	end

	retire_write_legal: assert property (@(posedge clk_i) disable iff (reset_i)
		retire_we_i |-> retire_valid_i && retire_rd_i != 5'd0)
	else begin
		fail_count++;
		$error("Register write retired without a valid slot or with destination x0.");
	end

	idle_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> !dmem_access_i)
	else begin
		fail_count++;
		$error("Data access active in the first cycle after reset.");
	end
endmodule

//--- sim/core_tb.sv
`timescale 1ns/1ps

module core_tb;
	localparam int CLK_PERIOD = 100;
	localparam int PROG_LEN = 400;
	localparam int PAD_LEN = 20;
	localparam int TIMEOUT_CYCLES = (PROG_LEN + PAD_LEN) * 20;
	localparam logic [9:0] R_FUNCTS [5] = '{10'h000, 10'h100, 10'h004, 10'h006, 10'h007};

	logic clk_i;
	logic reset_i;
	logic imem_access_o;
	logic [core_pkg::XLEN-1:0] imem_addr_o;
	logic [core_pkg::XLEN-1:0] imem_rd_data_i;
	logic imem_hit_i;
	logic dmem_access_o;
	logic dmem_write_o;
	logic [core_pkg::XLEN-1:0] dmem_addr_o;
	logic [core_pkg::XLEN-1:0] dmem_wr_data_o;
	logic [core_pkg::XLEN-1:0] dmem_rd_data_i;
	logic dmem_hit_i;
	logic retire_valid_o;
	logic retire_we_o;
	logic [4:0] retire_rd_o;
	logic [core_pkg::XLEN-1:0] retire_data_o;

	logic [31:0] rng_state = 32'h44c0;
	logic [core_pkg::XLEN-1:0] prog [PROG_LEN];
	logic [core_pkg::XLEN-1:0] data_mem [64];
	logic [core_pkg::XLEN-1:0] model_mem [64];
	logic [core_pkg::XLEN-1:0] model_regs [core_pkg::NUM_REGS];
	logic [core_pkg::XLEN-1:0] fetch_pc;
	int retired;

	core_top uut (.*);

	bind core_top core_checker checks (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.dmem_access_i(dmem_access_o),
		.dmem_write_i(dmem_write_o),
		.dmem_addr_i(dmem_addr_o),
		.retire_valid_i(retire_valid_o),
		.retire_we_i(retire_we_o),
		.retire_rd_i(retire_rd_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Registers x0 to x7 only, and loads and stores use x0 as base into a 64-word area.
	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [31:0] kind;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [11:0] off;
		logic [9:0] funct;
		r = next_random();
		kind = next_random() % 16;
		rd = {2'b00, r[2:0]};
		rs1 = {2'b00, r[5:3]};
		rs2 = {2'b00, r[8:6]};
		off = {4'b0000, r[14:9], 2'b00};
		funct = R_FUNCTS[r[17:15] % 5];
		case (kind)
		0, 1, 2: return {r[31:20], rs1, 3'b000, rd, 7'h13};
		3, 4: return {r[31:20], rs1, r[16] ? 3'b100 : (r[15] ? 3'b110 : 3'b111), rd, 7'h13};
		5: return {r[31:12], rd, 7'h37};
		6, 7, 8, 9: return {funct[9:3], rs2, rs1, funct[2:0], rd, 7'h33};
		10, 11, 12: return {off, 5'd0, 3'b010, rd, 7'h03};
		13, 14: return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'h23};
		default: return {r[31:7], 7'h0f}; // Unsupported opcode.
		endcase
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic mismatch(input string signal, input logic [core_pkg::XLEN-1:0] got,
		input logic [core_pkg::XLEN-1:0] expected);
		abort_run($sformatf("Mismatch on %s: got %h, expected %h", signal, got, expected));
	endtask

	task automatic retire_check(input logic got_we, input logic exp_we,
		input logic [4:0] got_rd, input logic [4:0] exp_rd,
		input logic [core_pkg::XLEN-1:0] got_data, input logic [core_pkg::XLEN-1:0] exp_data);
		if (got_we !== exp_we)
			mismatch("retire_we_o", got_we, exp_we);
		else if (exp_we && got_rd !== exp_rd)
			mismatch("retire_rd_o", got_rd, exp_rd);
		else if (exp_we && got_data !== exp_data)
			mismatch("retire_data_o", got_data, exp_data);
	endtask

	task automatic store_check(input logic [core_pkg::XLEN-1:0] got_addr,
		input logic [core_pkg::XLEN-1:0] exp_addr,
		input logic [core_pkg::XLEN-1:0] got_data, input logic [core_pkg::XLEN-1:0] exp_data);
		if (got_addr !== exp_addr)
			mismatch("dmem_addr_o", got_addr, exp_addr);
		else if (got_data !== exp_data)
			mismatch("dmem_wr_data_o", got_data, exp_data);
	endtask

	task automatic fetch_check(input logic [core_pkg::XLEN-1:0] got_addr,
		input logic [core_pkg::XLEN-1:0] exp_addr);
		if (got_addr !== exp_addr)
			mismatch("imem_addr_o", got_addr, exp_addr);
	endtask

	// Architectural model of the supported instructions, run at retirement.
	task automatic execute_model(input logic [31:0] instr, output logic we,
		output logic [4:0] rd, output logic [core_pkg::XLEN-1:0] val);
		logic [core_pkg::XLEN-1:0] a;
		logic [core_pkg::XLEN-1:0] b;
		logic [core_pkg::XLEN-1:0] imm;
		logic [core_pkg::XLEN-1:0] addr;
		a = model_regs[instr[19:15]];
		b = model_regs[instr[24:20]];
		imm = {{20{instr[31]}}, instr[31:20]};
		rd = instr[11:7];
		we = 1'b1;
		val = '0;
		case (instr[6:0])
		7'h13: begin
			case (instr[14:12])
			3'd0: val = a + imm;
			3'd4: val = a ^ imm;
			3'd6: val = a | imm;
			3'd7: val = a & imm;
			default: we = 1'b0;
			endcase
		end
		7'h33: begin
			case ({instr[31:25], instr[14:12]})
			10'h000: val = a + b;
			10'h100: val = a - b;
			10'h004: val = a ^ b;
			10'h006: val = a | b;
			10'h007: val = a & b;
			default: we = 1'b0;
			endcase
		end
		7'h37: val = {instr[31:12], 12'd0};
		7'h03: begin
			addr = a + imm;
			if (instr[14:12] == 3'b010)
				val = model_mem[addr[7:2]];
			else
				we = 1'b0;
		end
		7'h23: begin
			we = 1'b0;
			addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
			if (instr[14:12] == 3'b010)
				model_mem[addr[7:2]] = b;
		end
		default: we = 1'b0;
		endcase
		if (rd == 5'd0)
			we = 1'b0;
		if (we)
			model_regs[rd] = val;
	endtask

	task automatic drive_memories();
		logic [core_pkg::XLEN-1:0] index;
		index = (imem_addr_o - core_pkg::RESET_PC) >> 2;
		imem_rd_data_i = (index < PROG_LEN) ? prog[index] : core_pkg::NOP_INSTR; // NOP padding.
		imem_hit_i = (next_random() % 4) != 0;
		// The data array answers only an access.
		dmem_rd_data_i = dmem_access_o ? data_mem[dmem_addr_o[7:2]] : 'x;
		dmem_hit_i = (next_random() % 4) != 0;
	endtask

	task automatic observe_cycle();
		logic exp_we;
		logic [4:0] exp_rd;
		logic [core_pkg::XLEN-1:0] exp_data;
		logic [core_pkg::XLEN-1:0] exp_addr;
		logic [31:0] instr;
		if (uut.checks.fail_count != 0)
			abort_run("A concurrent assertion in the checker failed.");
		if (retire_valid_o) begin
			execute_model(prog[retired], exp_we, exp_rd, exp_data);
			retire_check(retire_we_o, exp_we, retire_rd_o, exp_rd, retire_data_o, exp_data);
			retired++;
		end
		if (imem_access_o && imem_hit_i) begin
			fetch_check(imem_addr_o, fetch_pc);
			fetch_pc = fetch_pc + 32'd4;
		end
		// Everything older than the access in MEM has retired by now.
		if (dmem_access_o) begin
			instr = prog[retired];
			if (instr[6:0] != (dmem_write_o ? 7'h23 : 7'h03))
				abort_run("A data access does not match the next instruction in order.");
			if (dmem_write_o && dmem_hit_i) begin
				exp_addr = model_regs[instr[19:15]] +
					{{20{instr[31]}}, instr[31:25], instr[11:7]};
				store_check(dmem_addr_o, exp_addr, dmem_wr_data_o, model_regs[instr[24:20]]);
				data_mem[dmem_addr_o[7:2]] = dmem_wr_data_o;
			end
		end
	endtask

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		abort_run("The program did not finish retiring before the watchdog expired.");
	end

	initial begin
		clk_i = 1'b0;
		reset_i = 1'b1;
		imem_rd_data_i = core_pkg::NOP_INSTR;
		imem_hit_i = 1'b0;
		dmem_rd_data_i = '0;
		dmem_hit_i = 1'b0;
		fetch_pc = core_pkg::RESET_PC;
		retired = 0;
		for (int i = 0; i < PROG_LEN; i++)
			prog[i] = random_instr();
		for (int i = 0; i < 64; i++) begin
			data_mem[i] = 32'hd00d_0000 | (i << 2); // Fill word follows its byte address.
			model_mem[i] = data_mem[i];
		end
		for (int i = 0; i < core_pkg::NUM_REGS; i++)
			model_regs[i] = '0;

		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		reset_i = 1'b0;
		while (retired < PROG_LEN) begin
			drive_memories();
			#1;
			observe_cycle();
			@(negedge clk_i);
		end

		if (uut.checks.fail_count != 0) begin
			abort_run("A concurrent assertion in the checker failed.");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end
endmodule

//--- vlog.f
verilog/core_pkg.sv
verilog/fetch_if.sv
verilog/mem_if.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/datapath.sv
verilog/core_top.sv
sim/core_checker.sv
sim/core_tb.sv

//--- Bender.yml
package:
  name: core

sources:
  - files:
      - verilog/core_pkg.sv
      - verilog/fetch_if.sv
      - verilog/mem_if.sv
      - verilog/decoder.sv
      - verilog/regfile.sv
      - verilog/alu.sv
      - verilog/hazard_unit.sv
      - verilog/datapath.sv
      - verilog/core_top.sv
  - target: simulation
    files:
      - sim/core_checker.sv
      - sim/core_tb.sv
